//--- filelist.f
source/region_pkg.sv
source/lsu_demux.sv
source/apb_mem_port.sv
source/ram_arbiter.sv
source/data_ram.sv
source/irq_encoder.sv
source/lsu_region.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/lsu_region_properties.sv
verification/tb_lsu_region.sv

//--- source/apb_mem_port.sv
//##########################################################################
// APB slave in front of the shared data RAM, no wait states beyond one.
// Every transfer takes setup, one access cycle for the RAM request and a
// second access cycle with pready_o. No pslverr: the RAM cannot fail.
// paddr_i is a byte address; bits above the RAM index wrap around.
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module apb_mem_port #(
  parameter int RAM_WORDS = 1024
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         psel_i,
  input  wire logic                         penable_i,
  input  wire logic                         pwrite_i,
  input  wire region_pkg::addr_t            paddr_i,
  input  wire region_pkg::word_t            pwdata_i,
  input  wire region_pkg::be_t              pstrb_i,
  output region_pkg::word_t                 prdata_o,
  output logic                              pready_o,
  output logic                              apb_ram_req_o,
  output logic                              apb_ram_we_o,
  output region_pkg::be_t                   apb_ram_be_o,
  output logic [$clog2(RAM_WORDS)-1:0]      apb_ram_index_o,
  output region_pkg::word_t                 apb_ram_wdata_o,
  input  wire region_pkg::word_t            apb_ram_rdata_i
);
  import region_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);

  apb_state_e state_q;
  apb_state_e state_d;

  // wait: setup seen, done: RAM data present, transfer completes
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      apb_idle: if (psel_i && !penable_i) state_d = apb_wait;
      apb_wait: begin
        if (psel_i && penable_i) begin
          state_d = apb_done;
        end else if (!psel_i) begin
          state_d = apb_idle;
        end
      end
      // back-to-back transfer may start its setup right away
      apb_done: state_d = (psel_i && !penable_i) ? apb_wait : apb_idle;
      default:  state_d = apb_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= apb_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // single request pulse in the first access cycle
  assign apb_ram_req_o   = (state_q == apb_wait) & psel_i & penable_i;
  assign apb_ram_we_o    = pwrite_i;
  assign apb_ram_be_o    = pstrb_i;
  assign apb_ram_index_o = paddr_i[IDX_W+1:2];
  assign apb_ram_wdata_o = pwdata_i;

  assign pready_o = (state_q == apb_done);
  assign prdata_o = apb_ram_rdata_i;

endmodule

`default_nettype wire

//--- source/data_ram.sv
//##########################################################################
// Single-port word RAM with byte enables and a registered read port.
// Read data appears one cycle after ram_en_i; a write also updates the
// read register with the old word. Contents are not reset.
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter int RAM_WORDS = 1024
) (
  input  wire logic                         clk,
  input  wire logic                         ram_en_i,
  input  wire logic                         ram_we_i,
  input  wire region_pkg::be_t              ram_be_i,
  input  wire logic [$clog2(RAM_WORDS)-1:0] ram_index_i,
  input  wire region_pkg::word_t            ram_wdata_i,
  output region_pkg::word_t                 ram_rdata_o
);
  localparam int NB_BYTES = $bits(ram_be_i);

  logic [31:0] mem [RAM_WORDS];

  always_ff @(posedge clk) begin
    if (ram_en_i) begin
      if (ram_we_i) begin
        for (int b = 0; b < NB_BYTES; b++) begin
          if (ram_be_i[b]) begin
            mem[ram_index_i][8*b +: 8] <= ram_wdata_i[8*b +: 8];
          end
        end
      end
      ram_rdata_o <= mem[ram_index_i];
    end
  end

endmodule

`default_nettype wire

//--- source/irq_encoder.sv
//##########################################################################
// Registered priority encoder of the 32 interrupt lines.
// The highest-numbered pending line wins. Outputs lag irq_i by one cycle
// and are both zero when no line is set.
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module irq_encoder (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire region_pkg::irq_vec_t  irq_i,
  output logic                       irq_valid_o,
  output region_pkg::irq_id_t        irq_id_o
);
  import region_pkg::*;

  irq_id_t irq_id_d;

  // later iterations overwrite, so the top set line is kept
  always_comb begin
    irq_id_d = '0;
    for (int i = 0; i < $bits(irq_vec_t); i++) begin
      if (irq_i[i]) irq_id_d = irq_id_t'(i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_valid_o <= 1'b0;
      irq_id_o    <= '0;
    end else begin
      irq_valid_o <= |irq_i;
      irq_id_o    <= irq_id_d;
    end
  end

endmodule

`default_nettype wire

//--- source/lsu_demux.sv
//##########################################################################
// Splits load/store requests between the local RAM and the external port.
// Assumes the core issues no new request before the previous response,
// so one bit of state is enough to route the read data back.
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module lsu_demux (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               lsu_req_i,
  input  wire region_pkg::addr_t  lsu_addr_i,
  input  wire logic               lsu_we_i,
  input  wire region_pkg::be_t    lsu_be_i,
  input  wire region_pkg::word_t  lsu_wdata_i,
  output logic                    lsu_gnt_o,
  output logic                    lsu_rvalid_o,
  output region_pkg::word_t       lsu_rdata_o,
  output logic                    ext_req_o,
  output region_pkg::addr_t       ext_addr_o,
  output logic                    ext_we_o,
  output region_pkg::be_t         ext_be_o,
  output region_pkg::word_t       ext_wdata_o,
  input  wire logic               ext_gnt_i,
  input  wire logic               ext_rvalid_i,
  input  wire region_pkg::word_t  ext_rdata_i,
  output logic                    core_ram_req_o,
  output region_pkg::addr_t       core_ram_addr_o,
  output logic                    core_ram_we_o,
  output region_pkg::be_t         core_ram_be_o,
  output region_pkg::word_t       core_ram_wdata_o,
  input  wire logic               core_ram_gnt_i,
  input  wire logic               core_ram_rvalid_i,
  input  wire region_pkg::word_t  core_ram_rdata_i
);
  import region_pkg::*;

  logic      is_local;
  resp_src_e resp_src_q;

  assign is_local = (region_tag_t'(lsu_addr_i[31:20]) == local_region_c);

  // request side is purely combinational
  assign core_ram_req_o   = lsu_req_i & is_local;
  assign core_ram_addr_o  = lsu_addr_i;
  assign core_ram_we_o    = lsu_we_i;
  assign core_ram_be_o    = lsu_be_i;
  assign core_ram_wdata_o = lsu_wdata_i;

  assign ext_req_o   = lsu_req_i & ~is_local;
  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o = is_local ? core_ram_gnt_i : (ext_req_o & ext_gnt_i);

  // remember which target took the last request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_src_q <= resp_ram;
    end else if (lsu_gnt_o) begin
      resp_src_q <= is_local ? resp_ram : resp_ext;
    end
  end

  assign lsu_rdata_o  = (resp_src_q == resp_ext) ? ext_rdata_i : core_ram_rdata_i;
  assign lsu_rvalid_o = core_ram_rvalid_i | ext_rvalid_i;

endmodule

`default_nettype wire

//--- source/lsu_region.sv
//##########################################################################
// Memory-side fabric around a load/store port.
// Local accesses (bits 31:20 == 12'h001) go to a shared data RAM that an
// APB slave port can also reach with priority; all others leave on ext_*.
// RAM_WORDS must be a power of two, at most 2**18.
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module lsu_region #(
  parameter int RAM_WORDS = 1024
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  lsu_req_i,
  input  wire region_pkg::addr_t     lsu_addr_i,
  input  wire logic                  lsu_we_i,
  input  wire region_pkg::be_t       lsu_be_i,
  input  wire region_pkg::word_t     lsu_wdata_i,
  output logic                       lsu_gnt_o,
  output logic                       lsu_rvalid_o,
  output region_pkg::word_t          lsu_rdata_o,
  output logic                       ext_req_o,
  output region_pkg::addr_t          ext_addr_o,
  output logic                       ext_we_o,
  output region_pkg::be_t            ext_be_o,
  output region_pkg::word_t          ext_wdata_o,
  input  wire logic                  ext_gnt_i,
  input  wire logic                  ext_rvalid_i,
  input  wire region_pkg::word_t     ext_rdata_i,
  input  wire logic                  psel_i,
  input  wire logic                  penable_i,
  input  wire logic                  pwrite_i,
  input  wire region_pkg::addr_t     paddr_i,
  input  wire region_pkg::word_t     pwdata_i,
  input  wire region_pkg::be_t       pstrb_i,
  output region_pkg::word_t          prdata_o,
  output logic                       pready_o,
  input  wire region_pkg::irq_vec_t  irq_i,
  output logic                       irq_valid_o,
  output region_pkg::irq_id_t        irq_id_o
);
  import region_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);

  // core side of the RAM arbiter
  logic  core_ram_req;
  addr_t core_ram_addr;
  logic  core_ram_we;
  be_t   core_ram_be;
  word_t core_ram_wdata;
  logic  core_ram_gnt;
  logic  core_ram_rvalid;
  word_t core_ram_rdata;

  // APB side of the RAM arbiter
  logic             apb_ram_req;
  logic             apb_ram_we;
  be_t              apb_ram_be;
  logic [IDX_W-1:0] apb_ram_index;
  word_t            apb_ram_wdata;
  word_t            apb_ram_rdata;

  // RAM macro port
  logic             ram_en;
  logic             ram_we;
  be_t              ram_be;
  logic [IDX_W-1:0] ram_index;
  word_t            ram_wdata;
  word_t            ram_rdata;

  lsu_demux u_lsu_demux (
    .clk               (clk),
    .rst_n             (rst_n),
    .lsu_req_i         (lsu_req_i),
    .lsu_addr_i        (lsu_addr_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_be_i          (lsu_be_i),
    .lsu_wdata_i       (lsu_wdata_i),
    .lsu_gnt_o         (lsu_gnt_o),
    .lsu_rvalid_o      (lsu_rvalid_o),
    .lsu_rdata_o       (lsu_rdata_o),
    .ext_req_o         (ext_req_o),
    .ext_addr_o        (ext_addr_o),
    .ext_we_o          (ext_we_o),
    .ext_be_o          (ext_be_o),
    .ext_wdata_o       (ext_wdata_o),
    .ext_gnt_i         (ext_gnt_i),
    .ext_rvalid_i      (ext_rvalid_i),
    .ext_rdata_i       (ext_rdata_i),
    .core_ram_req_o    (core_ram_req),
    .core_ram_addr_o   (core_ram_addr),
    .core_ram_we_o     (core_ram_we),
    .core_ram_be_o     (core_ram_be),
    .core_ram_wdata_o  (core_ram_wdata),
    .core_ram_gnt_i    (core_ram_gnt),
    .core_ram_rvalid_i (core_ram_rvalid),
    .core_ram_rdata_i  (core_ram_rdata)
  );

  apb_mem_port #(
    .RAM_WORDS (RAM_WORDS)
  ) u_apb_mem_port (
    .clk             (clk),
    .rst_n           (rst_n),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .pstrb_i         (pstrb_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .apb_ram_req_o   (apb_ram_req),
    .apb_ram_we_o    (apb_ram_we),
    .apb_ram_be_o    (apb_ram_be),
    .apb_ram_index_o (apb_ram_index),
    .apb_ram_wdata_o (apb_ram_wdata),
    .apb_ram_rdata_i (apb_ram_rdata)
  );

  ram_arbiter #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram_arbiter (
    .clk               (clk),
    .rst_n             (rst_n),
    .apb_ram_req_i     (apb_ram_req),
    .apb_ram_we_i      (apb_ram_we),
    .apb_ram_be_i      (apb_ram_be),
    .apb_ram_index_i   (apb_ram_index),
    .apb_ram_wdata_i   (apb_ram_wdata),
    .apb_ram_rdata_o   (apb_ram_rdata),
    .core_ram_req_i    (core_ram_req),
    .core_ram_addr_i   (core_ram_addr),
    .core_ram_we_i     (core_ram_we),
    .core_ram_be_i     (core_ram_be),
    .core_ram_wdata_i  (core_ram_wdata),
    .core_ram_gnt_o    (core_ram_gnt),
    .core_ram_rvalid_o (core_ram_rvalid),
    .core_ram_rdata_o  (core_ram_rdata),
    .ram_en_o          (ram_en),
    .ram_we_o          (ram_we),
    .ram_be_o          (ram_be),
    .ram_index_o       (ram_index),
    .ram_wdata_o       (ram_wdata),
    .ram_rdata_i       (ram_rdata)
  );

  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_data_ram (
    .clk         (clk),
    .ram_en_i    (ram_en),
    .ram_we_i    (ram_we),
    .ram_be_i    (ram_be),
    .ram_index_i (ram_index),
    .ram_wdata_i (ram_wdata),
    .ram_rdata_o (ram_rdata)
  );

  irq_encoder u_irq_encoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_i       (irq_i),
    .irq_valid_o (irq_valid_o),
    .irq_id_o    (irq_id_o)
  );

endmodule

`default_nettype wire

//--- source/ram_arbiter.sv
//##########################################################################
// Fixed-priority arbiter for the single-port data RAM.
// APB always wins and is served in its request cycle; the core port
// only gets a grant when APB is quiet. Core rvalid follows the grant
// by exactly one cycle, so grants can be issued back to back.
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module ram_arbiter #(
  parameter int RAM_WORDS = 1024
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         apb_ram_req_i,
  input  wire logic                         apb_ram_we_i,
  input  wire region_pkg::be_t              apb_ram_be_i,
  input  wire logic [$clog2(RAM_WORDS)-1:0] apb_ram_index_i,
  input  wire region_pkg::word_t            apb_ram_wdata_i,
  output region_pkg::word_t                 apb_ram_rdata_o,
  input  wire logic                         core_ram_req_i,
  input  wire region_pkg::addr_t            core_ram_addr_i,
  input  wire logic                         core_ram_we_i,
  input  wire region_pkg::be_t              core_ram_be_i,
  input  wire region_pkg::word_t            core_ram_wdata_i,
  output logic                              core_ram_gnt_o,
  output logic                              core_ram_rvalid_o,
  output region_pkg::word_t                 core_ram_rdata_o,
  output logic                              ram_en_o,
  output logic                              ram_we_o,
  output region_pkg::be_t                   ram_be_o,
  output logic [$clog2(RAM_WORDS)-1:0]      ram_index_o,
  output region_pkg::word_t                 ram_wdata_o,
  input  wire region_pkg::word_t            ram_rdata_i
);
  localparam int IDX_W = $clog2(RAM_WORDS);

  logic [IDX_W-1:0] core_index;
  logic             core_resp_q;

  // byte address to word index
  assign core_index = core_ram_addr_i[IDX_W+1:2];

  assign core_ram_gnt_o = core_ram_req_i & ~apb_ram_req_i;

  assign ram_en_o    = apb_ram_req_i | core_ram_req_i;
  assign ram_we_o    = apb_ram_req_i ? apb_ram_we_i    : core_ram_we_i;
  assign ram_be_o    = apb_ram_req_i ? apb_ram_be_i    : core_ram_be_i;
  assign ram_index_o = apb_ram_req_i ? apb_ram_index_i : core_index;
  assign ram_wdata_o = apb_ram_req_i ? apb_ram_wdata_i : core_ram_wdata_i;

  // marks the cycle in which the RAM output belongs to the core
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_resp_q <= 1'b0;
    end else begin
      core_resp_q <= core_ram_gnt_o;
    end
  end

  assign core_ram_rvalid_o = core_resp_q;
  assign core_ram_rdata_o  = ram_rdata_i;
  assign apb_ram_rdata_o   = ram_rdata_i;

endmodule

`default_nettype wire

//--- source/region_pkg.sv
//##########################################################################
// Shared types and constants of the load/store memory region.
// Data path is fixed at 32 bits with 4 byte enables.
// The local data RAM answers to addresses whose bits 31:20 equal
// local_region_c; everything else is routed to the external port.
//##########################################################################

`default_nettype none

package region_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  be_t;
  typedef logic [31:0] irq_vec_t;
  typedef logic [4:0]  irq_id_t;
  typedef logic [11:0] region_tag_t;

  // upper address field of the local data RAM
  localparam region_tag_t local_region_c = 12'h001;

  // source of the next load/store response
  typedef enum logic {resp_ram, resp_ext} resp_src_e;

  typedef enum logic [1:0] {apb_idle, apb_wait, apb_done} apb_state_e;

endpackage

`default_nettype wire

//--- verification/lsu_region_properties.sv
//##########################################################################
// Handshake assertions bound into lsu_region.
// Assumes at most one outstanding load/store request.
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module lsu_region_properties (
  input wire logic clk, rst_n, psel_i, penable_i, pready_o,
  input wire logic lsu_req_i, lsu_gnt_o, lsu_rvalid_o, ext_req_o, core_ram_req
);
  logic outstanding_q;
  int   fail_count = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 1'b0;
    end else if (lsu_req_i && lsu_gnt_o) begin
      outstanding_q <= 1'b1;
    end else if (lsu_rvalid_o) begin
      outstanding_q <= 1'b0;
    end
  end

  a_pready_access: assert property (@(posedge clk) disable iff (!rst_n)
    pready_o |-> (psel_i && penable_i))
  else begin
    $error("pready outside access phase");
    fail_count++;
  end
  a_rvalid_req: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_rvalid_o |-> outstanding_q)
  else begin
    $error("rvalid without request");
    fail_count++;
  end
  a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
    !(ext_req_o && core_ram_req))
  else begin
    $error("both targets requested");
    fail_count++;
  end
endmodule

bind lsu_region lsu_region_properties u_lsu_region_properties (
  .clk(clk), .rst_n(rst_n), .psel_i(psel_i), .penable_i(penable_i),
  .pready_o(pready_o), .lsu_req_i(lsu_req_i), .lsu_gnt_o(lsu_gnt_o),
  .lsu_rvalid_o(lsu_rvalid_o), .ext_req_o(ext_req_o), .core_ram_req(core_ram_req)
);

`default_nettype wire

//--- verification/tb_checker.sv
//##########################################################################
// Watches the DUT ports at each rising edge and compares against a RAM
// model and an external memory model. Assumes one core request at a time.
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter int RAM_WORDS = 1024
) (
  input wire logic clk, rst_n,
  input wire logic lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o,
  input wire logic [31:0] lsu_addr_i, lsu_wdata_i, lsu_rdata_o,
  input wire logic [3:0] lsu_be_i, ext_be_o,
  input wire logic ext_req_o, ext_we_o, ext_gnt_i,
  input wire logic [31:0] ext_addr_o, ext_wdata_o,
  input wire logic psel_i, penable_i, pwrite_i, pready_o,
  input wire logic [31:0] paddr_i, pwdata_i, prdata_o,
  input wire logic [3:0] pstrb_i,
  input wire logic [31:0] irq_i,
  input wire logic irq_valid_o,
  input wire logic [4:0] irq_id_o
);
  localparam int IDX_W = $clog2(RAM_WORDS);

  int error_count = 0;
  int check_count = 0;
  logic [31:0] ram_model [RAM_WORDS];
  logic [31:0] ext_model [logic [31:0]];
  logic setup_q = 0, apb_first_q = 0, local_q = 0, ext_q = 0, irq_ok = 0;
  logic read_q;
  logic [31:0] exp_rdata, exp_prdata, irq_q;

  task automatic flag_mismatch(string msg);
    error_count++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] wd, logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) old[8*b +: 8] = wd[8*b +: 8];
    end
    return old;
  endfunction

  function automatic logic [4:0] top_line(logic [31:0] v);
    for (int i = 31; i >= 0; i--) begin
      if (v[i]) return 5'(i);
    end
    return 5'd0;
  endfunction

  always @(posedge clk) begin
    logic apb_first, is_local;
    logic [31:0] a;
    if (!rst_n) begin
      check_count++;
      if (lsu_rvalid_o !== 1'b0 || ext_req_o !== 1'b0 || pready_o !== 1'b0 ||
          irq_valid_o !== 1'b0 || irq_id_o !== 5'd0)
        flag_mismatch("outputs not low during reset");
    end else begin
      // interrupts, one cycle behind irq_i
      if (irq_ok) begin
        check_count++;
        if (irq_valid_o !== (|irq_q) || irq_id_o !== top_line(irq_q))
          flag_mismatch($sformatf("irq got %b/%0d for %h", irq_valid_o, irq_id_o, irq_q));
      end
      irq_q  = irq_i;
      irq_ok = 1'b1;

      // APB: model update on the first access cycle, pready one cycle later
      apb_first = psel_i && penable_i && setup_q;
      if (pready_o !== apb_first_q)
        flag_mismatch("pready not in second access cycle");
      if (pready_o && apb_first_q && !pwrite_i) begin
        check_count++;
        if (prdata_o !== exp_prdata)
          flag_mismatch($sformatf("APB read %h, expected %h", prdata_o, exp_prdata));
      end
      if (apb_first) begin
        if (pwrite_i) begin
          ram_model[paddr_i[IDX_W+1:2]] =
            merge(ram_model[paddr_i[IDX_W+1:2]], pwdata_i, pstrb_i);
        end else begin
          exp_prdata = ram_model[paddr_i[IDX_W+1:2]];
        end
      end
      apb_first_q = apb_first;
      setup_q     = psel_i && !penable_i;

      // responses
      if (local_q && !lsu_rvalid_o)
        flag_mismatch("local rvalid missing one cycle after grant");
      if (lsu_rvalid_o) begin
        check_count++;
        if (!local_q && !ext_q) begin
          flag_mismatch("rvalid without outstanding request");
        end else if (read_q && lsu_rdata_o !== exp_rdata) begin
          flag_mismatch($sformatf("read data %h, expected %h", lsu_rdata_o, exp_rdata));
        end
        ext_q = 1'b0;
      end
      local_q = 1'b0;

      // requests
      is_local = (lsu_addr_i[31:20] == 12'h001);
      if (lsu_req_i && is_local && lsu_gnt_o !== !apb_first)
        flag_mismatch("local grant does not follow APB priority");
      if (lsu_req_i && !is_local && lsu_gnt_o !== ext_gnt_i)
        flag_mismatch("external grant does not follow ext_gnt_i");
      if (lsu_req_i && lsu_gnt_o) begin
        read_q = !lsu_we_i;
        if (is_local) begin
          local_q   = 1'b1;
          exp_rdata = ram_model[lsu_addr_i[IDX_W+1:2]];
          if (lsu_we_i)
            ram_model[lsu_addr_i[IDX_W+1:2]] = merge(exp_rdata, lsu_wdata_i, lsu_be_i);
        end else begin
          ext_q = 1'b1;
          check_count++;
          if (!ext_req_o || ext_addr_o !== lsu_addr_i || ext_we_o !== lsu_we_i ||
              ext_be_o !== lsu_be_i || ext_wdata_o !== lsu_wdata_i)
            flag_mismatch($sformatf("external request fields differ at %h", lsu_addr_i));
          a = {lsu_addr_i[31:2], 2'b00};
          exp_rdata = ext_model.exists(a) ? ext_model[a]
                    : ({a[15:0], ~a[31:16]} ^ 32'h3c3c_a5a5);
          if (lsu_we_i) ext_model[a] = merge(exp_rdata, lsu_wdata_i, lsu_be_i);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
//##########################################################################
// Free-running testbench clock, starts low at time zero.
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);
  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;
endmodule

`default_nettype wire

//--- verification/tb_lsu_region.sv
//##########################################################################
// Top testbench of lsu_region. Acts as core, APB master and external
// responder. Uses 16 local words, preloaded over APB before random traffic.
// Inputs change on the falling edge only.
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_lsu_region;
  import region_pkg::*;

  localparam int RAM_WORDS = 1024;
  localparam int N_CORE    = 300;
  localparam int N_APB     = 150;
  localparam int WAIT_MAX  = 50;

  logic clk, rst_n;
  logic lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o;
  addr_t lsu_addr_i;
  be_t lsu_be_i;
  word_t lsu_wdata_i, lsu_rdata_o;
  logic ext_req_o, ext_we_o, ext_gnt_i, ext_rvalid_i;
  addr_t ext_addr_o;
  be_t ext_be_o;
  word_t ext_wdata_o, ext_rdata_i;
  logic psel_i, penable_i, pwrite_i, pready_o;
  addr_t paddr_i;
  word_t pwdata_i, prdata_o;
  be_t pstrb_i;
  irq_vec_t irq_i;
  logic irq_valid_o;
  irq_id_t irq_id_o;

  int timeout_count;
  word_t ext_mem [addr_t];

  tb_clock_gen #(.PERIOD_NS(100)) u_clock_gen (.clk(clk));

  lsu_region #(.RAM_WORDS(RAM_WORDS)) u_lsu_region (.*);

  tb_checker #(.RAM_WORDS(RAM_WORDS)) u_checker (.*);

  // responder memory content before any write
  function automatic word_t ext_fill(addr_t a);
    return {a[15:0], ~a[31:16]} ^ 32'h3c3c_a5a5;
  endfunction

  task automatic core_access(addr_t a, logic we, be_t be, word_t wd);
    int n;
    @(negedge clk);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = a;
    lsu_we_i    = we;
    lsu_be_i    = be;
    lsu_wdata_i = wd;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!lsu_gnt_o && n < WAIT_MAX);
    @(negedge clk);
    lsu_req_i = 1'b0;
    if (n >= WAIT_MAX) begin
      timeout_count++;
      $display("timeout: core request to %h was never granted", a);
    end else begin
      n = 0;
      do begin
        @(posedge clk);
        n++;
      end while (!lsu_rvalid_o && n < WAIT_MAX);
      if (n >= WAIT_MAX) begin
        timeout_count++;
        $display("timeout: no response for core request to %h", a);
      end
    end
  endtask

  task automatic apb_transfer(addr_t a, logic we, be_t be, word_t wd);
    int n;
    @(negedge clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = we;
    paddr_i   = a;
    pstrb_i   = be;
    pwdata_i  = wd;
    @(negedge clk);
    penable_i = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!pready_o && n < WAIT_MAX);
    if (n >= WAIT_MAX) begin
      timeout_count++;
      $display("timeout: APB transfer to %h never got pready", a);
    end
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  // external responder, grant after 0..3 idle cycles
  initial begin
    addr_t a;
    word_t v;
    forever begin
      @(posedge clk);
      if (rst_n && ext_req_o && !ext_gnt_i) begin
        a = {ext_addr_o[31:2], 2'b00};
        repeat ($urandom_range(3, 0)) @(negedge clk);
        @(negedge clk);
        ext_gnt_i = 1'b1;
        v = ext_mem.exists(a) ? ext_mem[a] : ext_fill(a);
        if (ext_we_o) begin
          for (int b = 0; b < 4; b++) begin
            if (ext_be_o[b]) v[8*b +: 8] = ext_wdata_o[8*b +: 8];
          end
          ext_mem[a] = v;
        end
        @(negedge clk);
        ext_gnt_i = 1'b0;
        repeat ($urandom_range(2, 0)) @(negedge clk);
        ext_rvalid_i = 1'b1;
        ext_rdata_i  = v;
        @(negedge clk);
        ext_rvalid_i = 1'b0;
        ext_rdata_i  = $urandom;
      end
    end
  end

  // random interrupt patterns, often sparse or empty
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n) begin
        irq_i = ($urandom_range(3, 0) == 0) ? '0 : ($urandom & $urandom & $urandom);
      end
    end
  end

  initial begin
    void'($urandom(87));
    timeout_count = 0;
    rst_n         = 1'b0;
    {lsu_req_i, lsu_we_i, lsu_addr_i, lsu_be_i, lsu_wdata_i} = '0;
    {ext_gnt_i, ext_rvalid_i, ext_rdata_i} = '0;
    {psel_i, penable_i, pwrite_i, paddr_i, pwdata_i, pstrb_i} = '0;
    irq_i = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // preload the used words; upper address bits wrap
    for (int i = 0; i < 16; i++) begin
      apb_transfer({12'h000, 8'($urandom_range(255, 0)), 10'(i), 2'b00},
                   1'b1, 4'hf, $urandom);
    end

    fork
      for (int i = 0; i < N_CORE; i++) begin
        if ($urandom_range(2, 0) != 0) begin
          core_access(32'h0010_0000 | ($urandom_range(15, 0) << 2),
                      1'($urandom_range(1, 0)), 4'($urandom_range(15, 1)), $urandom);
        end else begin
          core_access(32'h4000_0000 | ($urandom_range(15, 0) << 2),
                      1'($urandom_range(1, 0)), 4'($urandom_range(15, 1)), $urandom);
        end
      end
      for (int i = 0; i < N_APB; i++) begin
        repeat ($urandom_range(3, 0)) @(negedge clk);
        apb_transfer({12'h000, 8'($urandom_range(255, 0)),
                      10'($urandom_range(15, 0)), 2'b00},
                     1'($urandom_range(1, 0)), 4'($urandom_range(15, 1)), $urandom);
      end
    join

    repeat (4) @(negedge clk);
    $display("checks: %0d  errors: %0d  timeouts: %0d  assertion failures: %0d",
             u_checker.check_count, u_checker.error_count, timeout_count,
             u_lsu_region.u_lsu_region_properties.fail_count);
    if (u_checker.error_count == 0 && timeout_count == 0 &&
        u_lsu_region.u_lsu_region_properties.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
